/* Bender.yml */
package:
  name: ooo_core

sources:
  - files:
      - rtl/ooo_pkg.sv
      - rtl/dispatch_unit.sv
      - rtl/rename_table.sv
      - rtl/physical_register_file.sv
      - rtl/reservation_station.sv
      - rtl/alu_stage.sv
      - rtl/reorder_buffer.sv
      - rtl/ooo_core.sv
  - target: test
    files:
      - dv/commit_checker.sv
      - dv/ooo_core_tb.sv

/* dv/commit_checker.sv */
`default_nettype none

module commit_checker (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                inst_req,
    input  wire ooo_pkg::inst_t      inst,
    input  wire logic                inst_ack,
    input  wire logic                commit_valid,
    input  wire logic                commit_we,
    input  wire ooo_pkg::arch_reg_t  commit_rd,
    input  wire ooo_pkg::word_t      commit_value,
    input  wire logic                test_end,
    input  wire logic [8*24-1:0]     test_name,
    input  wire logic                run_done,
    output int                       commits,
    output int                       errors
);
    import ooo_pkg::*;

    word_t      arch [ARCH_REGS];   // ISA view of x0 to x31
    logic       exp_we_q [$];
    arch_reg_t  exp_rd_q [$];
    word_t      exp_val_q [$];
    logic       prev_ack;
    logic       prev_req;
    logic       seen_req;
    int         recorded;
    int         base_commits;
    int         base_errors;

    task automatic record_inst(input inst_t i);
        arch_reg_t  rd;
        word_t      a;
        word_t      b;
        word_t      r;
        logic       is_op;
        logic       is_imm;
        is_op  = i[6:0] == 7'b0110011;
        is_imm = i[6:0] == 7'b0010011;
        rd     = i[11:7];
        a      = arch[i[19:15]];
        b      = is_op ? arch[i[24:20]] : {{20{i[31]}}, i[31:20]};
        case (i[14:12])
            3'd0: r = (is_op && i[30]) ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (i[30]) r = $signed(a) >>> b[4:0];
                else r = a >> b[4:0];
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        if ((is_op || is_imm) && rd != '0) begin
            arch[rd] = r;
        end
        exp_we_q.push_back((is_op || is_imm) && rd != '0);
        exp_rd_q.push_back(rd);
        exp_val_q.push_back(r);
        recorded++;
    endtask

    task automatic report_mismatch(input string sig, input word_t exp, input word_t act);
        errors++;
        $display("FAIL %0t %s expected %h actual %h", $time, sig, exp, act);
    endtask

    task automatic compare_commit();
        logic       ew;
        arch_reg_t  er;
        word_t      ev;
        commits++;
        if (exp_we_q.size() == 0) begin
            errors++;
            $display("commit at %0t with no instruction outstanding", $time);
        end else begin
            ew = exp_we_q.pop_front();
            er = exp_rd_q.pop_front();
            ev = exp_val_q.pop_front();
            if (commit_we !== ew) report_mismatch("commit_we", word_t'(ew), word_t'(commit_we));
            else if (ew) begin
                if (commit_rd !== er) report_mismatch("commit_rd", word_t'(er), word_t'(commit_rd));
                if (commit_value !== ev) report_mismatch("commit_value", ev, commit_value);
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < ARCH_REGS; k++) arch[k] = '0;
            exp_we_q.delete();
            exp_rd_q.delete();
            exp_val_q.delete();
            {prev_ack, prev_req, seen_req} = '0;
            {commits, errors, recorded, base_commits, base_errors} = '0;
        end else begin
            if (!seen_req && (inst_ack || commit_valid)) begin
                errors++;
                $display("inst_ack or commit_valid high before any request at %0t", $time);
            end
            seen_req = seen_req || inst_req;
            if (inst_ack && !prev_ack) begin
                // the rise comes from the edge before, where req had to be high
                if (!prev_req) begin
                    errors++;
                    $display("inst_ack rose while inst_req was low at %0t", $time);
                end
                record_inst(inst); // ack only rises on a dispatch
            end
            if (!inst_ack && prev_ack && prev_req) begin
                errors++;
                $display("inst_ack fell while inst_req was still high at %0t", $time);
            end
            if (commit_valid) compare_commit();
            prev_ack = inst_ack;
            prev_req = inst_req;
            if (test_end) begin
                $display("test %0s %s, %0d commits, %0d errors", test_name,
                         errors == base_errors ? "passed" : "failed",
                         commits - base_commits, errors - base_errors);
                base_commits = commits;
                base_errors  = errors;
            end
            if (run_done) begin
                $display("totals: %0d handshakes, %0d commits, %0d errors",
                         recorded, commits, errors);
            end
        end
    end

endmodule

`default_nettype wire

/* dv/ooo_core_tb.sv */
`default_nettype none

module ooo_core_tb;
    import ooo_pkg::*;

    localparam int          CLK_PERIOD = 4;
    localparam int unsigned SEED       = 32'h4b4a8952;
    localparam int          N_MIX      = 200;
    localparam int          N_DEP      = 150;
    localparam int          N_X0       = 60;
    localparam int          N_RECYCLE  = 300;
    localparam int          N_TOTAL    = N_MIX + N_DEP + N_X0 + N_RECYCLE;
    localparam int          TIMEOUT    = N_TOTAL * 40 * CLK_PERIOD;

    logic              clk;
    logic              rst;
    logic              inst_req;
    inst_t             inst;
    logic              inst_ack;
    logic              commit_valid;
    logic              commit_we;
    arch_reg_t         commit_rd;
    word_t             commit_value;
    logic              test_end;
    logic              run_done;
    logic [8*24-1:0]   test_name;
    int                commits;
    int                errors;
    int                sent;
    int unsigned       seed;

    ooo_core UUT (.*);

    commit_checker u_commit_checker (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic arch_reg_t pick_reg(input int lo, input int hi);
        return arch_reg_t'(lo + int'($urandom % (hi - lo + 1)));
    endfunction

    function automatic inst_t alu_inst(input int lo, input int hi, input logic zero_rd);
        arch_reg_t   rd;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        inst_t       i;
        rd  = zero_rd ? arch_reg_t'(0) : pick_reg(lo, hi);
        f3  = 3'($urandom);
        alt = 1'($urandom);
        if ($urandom % 2 == 0) begin
            // funct7 bit 5 only where sub or sra exist
            i = {((alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0000000),
                 pick_reg(lo, hi), pick_reg(lo, hi), f3, rd, OPC_OP};
        end else begin
            if (f3 == 3'b001 || f3 == 3'b101) begin
                imm = {((alt && f3 == 3'b101) ? 7'b0100000 : 7'b0000000), 5'($urandom)};
            end else begin
                imm = 12'($urandom);
            end
            i = {imm, pick_reg(lo, hi), f3, rd, OPC_OP_IMM};
        end
        return i;
    endfunction

    function automatic inst_t other_inst();
        logic [6:0] opc;
        case ($urandom % 5)
            0: opc = 7'b0000011;       // load
            1: opc = 7'b0100011;       // store
            2: opc = 7'b1100011;       // branch
            3: opc = 7'b0110111;       // lui
            default: opc = 7'b1110011; // system
        endcase
        return {25'($urandom), opc};
    endfunction

    // entered on a falling edge, leaves on the falling edge that sees ack low
    task automatic send_inst(input inst_t i, input int gap);
        inst     = i;
        inst_req = 1'b1;
        do @(negedge clk); while (!inst_ack);
        inst_req = 1'b0;
        sent++;
        do @(negedge clk); while (inst_ack);
        repeat (gap) @(negedge clk);
    endtask

    task automatic end_test();
        while (commits < sent) @(negedge clk);
        test_end = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
    endtask

    task automatic run_phase(input int count, input int lo, input int hi,
                             input int other_pct, input int x0_pct, input int max_gap);
        inst_t i;
        for (int n = 0; n < count; n++) begin
            if ($urandom % 100 < other_pct) i = other_inst();
            else i = alu_inst(lo, hi, $urandom % 100 < x0_pct);
            send_inst(i, int'($urandom % (max_gap + 1)));
        end
        end_test();
    endtask

    initial begin
        rst       = 1'b1;
        inst_req  = 1'b0;
        inst      = '0;
        test_end  = 1'b0;
        run_done  = 1'b0;
        sent      = 0;
        test_name = "reset_idle";
        seed      = SEED;
        void'($urandom(seed));
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (10) @(negedge clk); // no request yet, outputs must stay quiet
        end_test();
        test_name = "random_alu_mix";
        run_phase(N_MIX, 0, 31, 5, 0, 3);
        test_name = "dependency_chains";
        run_phase(N_DEP, 1, 3, 0, 0, 2);
        test_name = "x0_and_unsupported";
        run_phase(N_X0, 0, 4, 30, 40, 2);
        test_name = "recycle_backpressure";
        run_phase(N_RECYCLE, 1, 31, 0, 0, 0);
        run_done = 1'b1;
        @(negedge clk);
        run_done = 1'b0;
        if (errors == 0 && commits == sent) begin
            $display("Simulation passed");
        end else begin
            if (commits != sent) $display("%0d instructions sent but %0d committed", sent, commits);
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("timeout: test %0s still running, %0d of %0d instructions committed",
                 test_name, commits, sent);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* ooo_core.f */
rtl/ooo_pkg.sv
rtl/dispatch_unit.sv
rtl/rename_table.sv
rtl/physical_register_file.sv
rtl/reservation_station.sv
rtl/alu_stage.sv
rtl/reorder_buffer.sv
rtl/ooo_core.sv
dv/commit_checker.sv
dv/ooo_core_tb.sv

/* rtl/alu_stage.sv */
`default_nettype none

module alu_stage (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                iss_valid,
    input  wire ooo_pkg::alu_op_t    iss_op,
    input  wire ooo_pkg::word_t      iss_data1,
    input  wire ooo_pkg::word_t      iss_data2,
    input  wire logic                iss_use_imm,
    input  wire ooo_pkg::word_t      iss_imm,
    input  wire ooo_pkg::phys_reg_t  iss_dest,
    input  wire ooo_pkg::rob_idx_t   iss_rob,
    output logic                     wb_valid,
    output ooo_pkg::phys_reg_t       wb_tag,
    output ooo_pkg::word_t           wb_value,
    output ooo_pkg::rob_idx_t        wb_rob
);
    import ooo_pkg::*;

    word_t  opb;
    word_t  result;

    assign opb = iss_use_imm ? iss_imm : iss_data2;

    always_comb begin
        case (iss_op)
            ALU_ADD:  result = iss_data1 + opb;
            ALU_SUB:  result = iss_data1 - opb;
            ALU_SLL:  result = iss_data1 << opb[4:0];
            ALU_SLT:  result = word_t'($signed(iss_data1) < $signed(opb));
            ALU_SLTU: result = word_t'(iss_data1 < opb);
            ALU_XOR:  result = iss_data1 ^ opb;
            ALU_SRL:  result = iss_data1 >> opb[4:0];
            ALU_SRA:  result = $signed(iss_data1) >>> opb[4:0];
            ALU_OR:   result = iss_data1 | opb;
            ALU_AND:  result = iss_data1 & opb;
            default:  result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= iss_valid;
        end
    end

    // broadcast payload
    always_ff @(posedge clk) begin
        wb_tag   <= iss_dest;
        wb_value <= result;
        wb_rob   <= iss_rob;
    end

endmodule

`default_nettype wire

/* rtl/dispatch_unit.sv */
`default_nettype none

module dispatch_unit (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                inst_req,
    input  wire ooo_pkg::inst_t      inst,
    input  wire logic                rob_full,
    input  wire logic                free_empty,
    input  wire logic                rs_full,
    output logic                     inst_ack,
    output logic                     disp_valid,
    output logic                     disp_alu,
    output logic                     disp_we,
    output ooo_pkg::arch_reg_t       disp_rs1,
    output ooo_pkg::arch_reg_t       disp_rs2,
    output ooo_pkg::arch_reg_t       disp_rd,
    output ooo_pkg::alu_op_t         disp_op,
    output logic                     disp_use_imm,
    output ooo_pkg::word_t           disp_imm
);
    import ooo_pkg::*;

    hs_state_t   state;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        is_op;
    logic        is_op_imm;
    logic        alt;
    logic        slot_free;

    assign opcode    = inst[6:0];
    assign funct3    = inst[14:12];
    assign is_op     = opcode == OPC_OP;
    assign is_op_imm = opcode == OPC_OP_IMM;

    assign disp_rd      = inst[11:7];
    assign disp_rs1     = inst[19:15];
    assign disp_rs2     = is_op ? inst[24:20] : '0; // imm forms read x0, always ready
    assign disp_use_imm = is_op_imm;
    assign disp_imm     = {{20{inst[31]}}, inst[31:20]};

    // funct7[5] only counts for sub and the right shifts
    assign alt     = inst[30] && (funct3 == 3'b101 || (is_op && funct3 == 3'b000));
    assign disp_op = alu_op_t'({alt, funct3});

    // x0 results are dropped, so those never reach the station
    assign disp_alu  = (is_op || is_op_imm) && disp_rd != '0;
    assign slot_free = !rob_full && (!disp_alu || (!free_empty && !rs_full));

    assign disp_valid = state == HS_IDLE && inst_req && slot_free;
    assign disp_we    = disp_valid && disp_alu;
    assign inst_ack   = state == HS_ACK;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= HS_IDLE;
        end else begin
            case (state)
                HS_IDLE: if (disp_valid) state <= HS_ACK;
                HS_ACK:  if (!inst_req) state <= HS_IDLE; // wait for req to drop
                default: state <= HS_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/ooo_core.sv */
`default_nettype none

module ooo_core (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                inst_req,
    input  wire ooo_pkg::inst_t      inst,
    output logic                     inst_ack,
    output logic                     commit_valid,
    output logic                     commit_we,
    output ooo_pkg::arch_reg_t       commit_rd,
    output ooo_pkg::word_t           commit_value
);
    import ooo_pkg::*;

    // dispatch
    logic       disp_valid;
    logic       disp_alu;
    logic       disp_we;
    logic       disp_use_imm;
    arch_reg_t  disp_rs1;
    arch_reg_t  disp_rs2;
    arch_reg_t  disp_rd;
    alu_op_t    disp_op;
    word_t      disp_imm;
    logic       rob_full;
    logic       free_empty;
    logic       rs_full;

    // rename
    phys_reg_t  src1_tag;
    phys_reg_t  src2_tag;
    phys_reg_t  new_tag;
    phys_reg_t  old_tag;
    logic       src1_ready;
    logic       src2_ready;

    // issue
    logic       iss_valid;
    alu_op_t    iss_op;
    phys_reg_t  iss_tag1;
    phys_reg_t  iss_tag2;
    logic       iss_use_imm;
    word_t      iss_imm;
    phys_reg_t  iss_dest;
    rob_idx_t   iss_rob;
    word_t      iss_data1;
    word_t      iss_data2;

    // result broadcast
    logic       wb_valid;
    phys_reg_t  wb_tag;
    word_t      wb_value;
    rob_idx_t   wb_rob;

    // retire
    rob_idx_t   rob_tail;
    phys_reg_t  ret_tag;
    word_t      ret_value;
    logic       free_valid;
    phys_reg_t  free_tag;

    dispatch_unit u_dispatch_unit (.*);

    rename_table u_rename_table (.*);

    physical_register_file u_physical_register_file (
        .alloc_valid (disp_we),
        .alloc_tag   (new_tag),
        .*
    );

    reservation_station u_reservation_station (.*);

    alu_stage u_alu_stage (.*);

    reorder_buffer u_reorder_buffer (.*);

endmodule

`default_nettype wire

/* rtl/ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

    localparam int XLEN      = 32;
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;
    localparam int ROB_DEPTH = 16;
    localparam int RS_DEPTH  = 4;

    typedef logic [XLEN-1:0]              word_t;
    typedef logic [31:0]                  inst_t;
    typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(PHYS_REGS)-1:0] phys_reg_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;

    // {funct7[5], funct3}
    typedef logic [3:0] alu_op_t;

    localparam alu_op_t ALU_ADD  = 4'b0000;
    localparam alu_op_t ALU_SUB  = 4'b1000;
    localparam alu_op_t ALU_SLL  = 4'b0001;
    localparam alu_op_t ALU_SLT  = 4'b0010;
    localparam alu_op_t ALU_SLTU = 4'b0011;
    localparam alu_op_t ALU_XOR  = 4'b0100;
    localparam alu_op_t ALU_SRL  = 4'b0101;
    localparam alu_op_t ALU_SRA  = 4'b1101;
    localparam alu_op_t ALU_OR   = 4'b0110;
    localparam alu_op_t ALU_AND  = 4'b0111;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    typedef enum logic {HS_IDLE, HS_ACK} hs_state_t;

endpackage

`default_nettype wire

/* rtl/physical_register_file.sv */
`default_nettype none

module physical_register_file (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire ooo_pkg::phys_reg_t  src1_tag,
    input  wire ooo_pkg::phys_reg_t  src2_tag,
    input  wire logic                alloc_valid,
    input  wire ooo_pkg::phys_reg_t  alloc_tag,
    input  wire ooo_pkg::phys_reg_t  iss_tag1,
    input  wire ooo_pkg::phys_reg_t  iss_tag2,
    input  wire logic                wb_valid,
    input  wire ooo_pkg::phys_reg_t  wb_tag,
    input  wire ooo_pkg::word_t      wb_value,
    input  wire ooo_pkg::phys_reg_t  ret_tag,
    output logic                     src1_ready,
    output logic                     src2_ready,
    output ooo_pkg::word_t           iss_data1,
    output ooo_pkg::word_t           iss_data2,
    output ooo_pkg::word_t           ret_value
);
    import ooo_pkg::*;

    word_t                 regs [PHYS_REGS];
    logic [PHYS_REGS-1:0]  ready;

    assign src1_ready = ready[src1_tag];
    assign src2_ready = ready[src2_tag];
    assign iss_data1  = regs[iss_tag1];
    assign iss_data2  = regs[iss_tag2];
    assign ret_value  = regs[ret_tag];

    // free tags start ready too, allocation clears them
    always_ff @(posedge clk) begin
        if (rst) begin
            ready <= '1;
        end else begin
            if (alloc_valid) ready[alloc_tag] <= 1'b0;
            if (wb_valid) ready[wb_tag] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid) begin
            regs[wb_tag] <= wb_value;
        end
    end

endmodule

`default_nettype wire

/* rtl/rename_table.sv */
`default_nettype none

module rename_table (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                disp_valid,
    input  wire logic                disp_we,
    input  wire ooo_pkg::arch_reg_t  disp_rs1,
    input  wire ooo_pkg::arch_reg_t  disp_rs2,
    input  wire ooo_pkg::arch_reg_t  disp_rd,
    input  wire logic                free_valid,
    input  wire ooo_pkg::phys_reg_t  free_tag,
    output ooo_pkg::phys_reg_t       src1_tag,
    output ooo_pkg::phys_reg_t       src2_tag,
    output ooo_pkg::phys_reg_t       new_tag,
    output ooo_pkg::phys_reg_t       old_tag,
    output logic                     free_empty
);
    import ooo_pkg::*;

    localparam int FREE_DEPTH = PHYS_REGS - ARCH_REGS;
    localparam int FREE_AW    = $clog2(FREE_DEPTH);

    phys_reg_t           rat [ARCH_REGS];
    phys_reg_t           free_list [FREE_DEPTH];
    logic [FREE_AW-1:0]  rd_ptr;
    logic [FREE_AW-1:0]  wr_ptr;
    logic [FREE_AW:0]    free_count;
    logic                pop;

    assign pop = disp_valid && disp_we;

    // sources see the mapping from before this dispatch
    assign src1_tag = rat[disp_rs1];
    assign src2_tag = rat[disp_rs2];
    assign old_tag  = rat[disp_rd];

    assign new_tag    = free_list[rd_ptr];
    assign free_empty = free_count == '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                rat[i] <= phys_reg_t'(i); // identity map
            end
        end else if (pop) begin
            rat[disp_rd] <= new_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < FREE_DEPTH; i++) begin
                free_list[i] <= phys_reg_t'(ARCH_REGS + i);
            end
            rd_ptr     <= '0;
            wr_ptr     <= '0;   // full, so write side wraps onto read side
            free_count <= (FREE_AW + 1)'(FREE_DEPTH);
        end else begin
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (free_valid) begin
                free_list[wr_ptr] <= free_tag;
                wr_ptr            <= wr_ptr + 1'b1;
            end
            free_count <= free_count + (FREE_AW + 1)'(free_valid) - (FREE_AW + 1)'(pop);
        end
    end

endmodule

`default_nettype wire

/* rtl/reorder_buffer.sv */
`default_nettype none

module reorder_buffer (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                disp_valid,
    input  wire logic                disp_alu,
    input  wire logic                disp_we,
    input  wire ooo_pkg::arch_reg_t  disp_rd,
    input  wire ooo_pkg::phys_reg_t  new_tag,
    input  wire ooo_pkg::phys_reg_t  old_tag,
    input  wire logic                wb_valid,
    input  wire ooo_pkg::rob_idx_t   wb_rob,
    input  wire ooo_pkg::word_t      ret_value,
    output logic                     rob_full,
    output ooo_pkg::rob_idx_t        rob_tail,
    output ooo_pkg::phys_reg_t       ret_tag,
    output logic                     commit_valid,
    output logic                     commit_we,
    output ooo_pkg::arch_reg_t       commit_rd,
    output ooo_pkg::word_t           commit_value,
    output logic                     free_valid,
    output ooo_pkg::phys_reg_t       free_tag
);
    import ooo_pkg::*;

    logic [ROB_DEPTH-1:0]          done;
    logic [ROB_DEPTH-1:0]          we;
    arch_reg_t                     rd    [ROB_DEPTH];
    phys_reg_t                     new_t [ROB_DEPTH];
    phys_reg_t                     old_t [ROB_DEPTH];
    rob_idx_t                      head;
    logic [$clog2(ROB_DEPTH):0]    count;

    assign rob_full     = count == ROB_DEPTH;
    assign commit_valid = count != '0 && done[head];
    assign commit_we    = commit_valid && we[head];
    assign commit_rd    = rd[head];
    assign commit_value = we[head] ? ret_value : '0;
    assign ret_tag      = new_t[head];

    // the mapping this entry replaced goes back to the free list
    assign free_valid = commit_we;
    assign free_tag   = old_t[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            head     <= '0;
            rob_tail <= '0;
            count    <= '0;
        end else begin
            if (disp_valid) rob_tail <= rob_tail + 1'b1;
            if (commit_valid) head <= head + 1'b1;
            count <= count + (disp_valid ? 1'b1 : 1'b0) - (commit_valid ? 1'b1 : 1'b0);
        end
    end

    always_ff @(posedge clk) begin
        if (disp_valid) begin
            done[rob_tail]  <= !disp_alu; // nothing to execute
            we[rob_tail]    <= disp_we;
            rd[rob_tail]    <= disp_rd;
            new_t[rob_tail] <= new_tag;
            old_t[rob_tail] <= old_tag;
        end
        if (wb_valid) begin
            done[wb_rob] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/reservation_station.sv */
`default_nettype none

module reservation_station (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                disp_valid,
    input  wire logic                disp_alu,
    input  wire ooo_pkg::alu_op_t    disp_op,
    input  wire ooo_pkg::phys_reg_t  src1_tag,
    input  wire ooo_pkg::phys_reg_t  src2_tag,
    input  wire logic                src1_ready,
    input  wire logic                src2_ready,
    input  wire logic                disp_use_imm,
    input  wire ooo_pkg::word_t      disp_imm,
    input  wire ooo_pkg::phys_reg_t  new_tag,
    input  wire ooo_pkg::rob_idx_t   rob_tail,
    input  wire logic                wb_valid,
    input  wire ooo_pkg::phys_reg_t  wb_tag,
    output logic                     rs_full,
    output logic                     iss_valid,
    output ooo_pkg::alu_op_t         iss_op,
    output ooo_pkg::phys_reg_t       iss_tag1,
    output ooo_pkg::phys_reg_t       iss_tag2,
    output logic                     iss_use_imm,
    output ooo_pkg::word_t           iss_imm,
    output ooo_pkg::phys_reg_t       iss_dest,
    output ooo_pkg::rob_idx_t        iss_rob
);
    import ooo_pkg::*;

    localparam int RS_AW = $clog2(RS_DEPTH);

    logic [RS_DEPTH-1:0]  valid;
    logic [RS_DEPTH-1:0]  rdy1;
    logic [RS_DEPTH-1:0]  rdy2;
    logic [RS_DEPTH-1:0]  use_imm;
    alu_op_t              op   [RS_DEPTH];
    phys_reg_t            tag1 [RS_DEPTH];
    phys_reg_t            tag2 [RS_DEPTH];
    word_t                imm  [RS_DEPTH];
    phys_reg_t            dest [RS_DEPTH];
    rob_idx_t             rob  [RS_DEPTH];
    logic [RS_AW-1:0]     free_idx;
    logic [RS_AW-1:0]     iss_idx;
    logic                 enq;

    assign enq     = disp_valid && disp_alu;
    assign rs_full = &valid;

    // downward scan, so the lowest index wins both picks
    always_comb begin
        free_idx  = '0;
        iss_idx   = '0;
        iss_valid = 1'b0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) free_idx = RS_AW'(i);
            if (valid[i] && rdy1[i] && rdy2[i]) begin
                iss_idx   = RS_AW'(i);
                iss_valid = 1'b1;
            end
        end
    end

    assign iss_op      = op[iss_idx];
    assign iss_tag1    = tag1[iss_idx];
    assign iss_tag2    = tag2[iss_idx];
    assign iss_use_imm = use_imm[iss_idx];
    assign iss_imm     = imm[iss_idx];
    assign iss_dest    = dest[iss_idx];
    assign iss_rob     = rob[iss_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (wb_valid && tag1[i] == wb_tag) rdy1[i] <= 1'b1;
                if (wb_valid && tag2[i] == wb_tag) rdy2[i] <= 1'b1;
            end
            if (iss_valid) valid[iss_idx] <= 1'b0;
            if (enq) begin
                valid[free_idx] <= 1'b1;
                // catch a broadcast landing in the dispatch cycle
                rdy1[free_idx] <= src1_ready || (wb_valid && src1_tag == wb_tag);
                rdy2[free_idx] <= src2_ready || (wb_valid && src2_tag == wb_tag);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enq) begin
            op[free_idx]      <= disp_op;
            tag1[free_idx]    <= src1_tag;
            tag2[free_idx]    <= src2_tag;
            use_imm[free_idx] <= disp_use_imm;
            imm[free_idx]     <= disp_imm;
            dest[free_idx]    <= new_tag;
            rob[free_idx]     <= rob_tail;
        end
    end

endmodule

`default_nettype wire
